// ==== vlog.f ====
common/mipsPkg.sv
source/mipsAlu.sv
source/mipsRegFile.sv
control/mipsControl.sv
source/mipsCpuBus.sv
bench/mipsChecker.sv
bench/mipsCpuTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= mipsCpuTb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0

SOURCES := $(shell cat $(FILELIST))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -q "^Simulation passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== bench/mipsCpuTb.sv ====
`timescale 1ns/1ps

module mipsCpuTb import mipsPkg::*; ();

    localparam wordT RESET_VECTOR = 32'hBFC00000;
    localparam int   NUM_TESTS    = 3;
    localparam int   MAX_WORDS    = 24;

    logic clk = 1'b0;
    logic reset;
    logic waitrequest = 1'b0;
    wordT readdata = '0;
    logic active;
    logic write;
    logic read;
    wordT registerV0;
    wordT address;
    wordT writedata;
    logic [3:0] byteenable;

    // one program and its expected results per entry
    wordT progWords [NUM_TESTS][MAX_WORDS];
    int   progLen [NUM_TESTS];
    wordT tabV0 [NUM_TESTS];
    logic tabStore [NUM_TESTS];
    wordT tabStoreAddr [NUM_TESTS];
    wordT tabStoreData [NUM_TESTS];
    int   tabFetches [NUM_TESTS];

    logic checkNow = 1'b0;
    wordT expV0 = '0;
    logic expStore = 1'b0;
    wordT expStoreAddr = '0;
    wordT expStoreData = '0;
    int   expFetches = 0;
    int   errorCount;
    int   checkCount;

    wordT mem [wordT];              // sparse word memory
    wordT lfsr = 32'hbf0c6034;
    logic waitBitA;
    logic waitBitB;
    int   cycleCount = 0;
    int   cycleLimit = 0;

    mipsCpuBus #(
        .resetVector(RESET_VECTOR)
    ) u_dut (
        .clk(clk),
        .reset(reset),
        .active(active),
        .register_v0(registerV0),
        .address(address),
        .write(write),
        .read(read),
        .waitrequest(waitrequest),
        .writedata(writedata),
        .byteenable(byteenable),
        .readdata(readdata)
    );

    mipsChecker #(
        .progBase(RESET_VECTOR)
    ) uChecker (
        .clk(clk),
        .reset(reset),
        .active(active),
        .registerV0(registerV0),
        .address(address),
        .write(write),
        .read(read),
        .waitrequest(waitrequest),
        .writedata(writedata),
        .byteenable(byteenable),
        .checkNow(checkNow),
        .expV0(expV0),
        .expStore(expStore),
        .expStoreAddr(expStoreAddr),
        .expStoreData(expStoreData),
        .expFetches(expFetches),
        .errorCount(errorCount),
        .checkCount(checkCount)
    );

    always #10 clk = ~clk;

    function automatic wordT lfsrNext(wordT s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    function automatic wordT rType(int rs, int rt, int rd, logic [5:0] fn);
        return {6'h00, 5'(rs), 5'(rt), 5'(rd), 5'h00, fn};
    endfunction

    function automatic wordT iType(logic [5:0] op, int rs, int rt, int imm);
        return {op, 5'(rs), 5'(rt), 16'(imm)};
    endfunction

    task automatic emit(int t, wordT w);
        progWords[t][progLen[t]] = w;
        progLen[t]++;
    endtask

    task automatic setExpected(int t, wordT v0, logic store, wordT addr, wordT data, int fetches);
        tabV0[t]        = v0;
        tabStore[t]     = store;
        tabStoreAddr[t] = addr;
        tabStoreData[t] = data;
        tabFetches[t]   = fetches;
    endtask

    task automatic buildTable();
        // arithmetic and logic, $zero written once
        emit(0, iType(6'h09, 0, 8, 'h1234));    // addiu $8, $0, 0x1234
        emit(0, iType(6'h09, 0, 9, -5));        // addiu $9, $0, -5
        emit(0, iType(6'h0F, 0, 10, 'h8000));   // lui   $10, 0x8000
        emit(0, iType(6'h0D, 10, 10, 'h00F0));  // ori   $10, $10, 0xf0
        emit(0, rType(8, 9, 11, 6'h21));        // addu  $11 = 0x122f
        emit(0, rType(8, 9, 12, 6'h23));        // subu  $12 = 0x1239
        emit(0, rType(11, 12, 13, 6'h24));      // and   $13 = 0x1229
        emit(0, rType(11, 12, 14, 6'h25));      // or    $14 = 0x123f
        emit(0, rType(13, 14, 15, 6'h26));      // xor   $15 = 0x16
        emit(0, rType(10, 8, 16, 6'h2A));       // slt   $16 = 1
        emit(0, rType(10, 8, 17, 6'h2B));       // sltu  $17 = 0
        emit(0, iType(6'h0C, 9, 18, 'hFF0F));   // andi  $18 = 0xff0b
        emit(0, iType(6'h0E, 18, 19, 'hFFFF));  // xori  $19 = 0xf4
        emit(0, iType(6'h09, 8, 0, 7));         // addiu $0, $8, 7
        emit(0, rType(19, 10, 2, 6'h26));       // xor   $2 = 0x80000004
        emit(0, rType(2, 15, 2, 6'h21));
        emit(0, rType(2, 16, 2, 6'h23));
        emit(0, rType(2, 17, 2, 6'h21));
        emit(0, rType(2, 0, 2, 6'h25));         // or with $0 must not change $2
        emit(0, rType(0, 0, 0, 6'h08));         // jr $0
        emit(0, iType(6'h09, 2, 2, 'h100));     // delay slot
        setExpected(0, 32'h8000_0119, 1'b0, '0, '0, 21);

        // store then load back into v0
        emit(1, iType(6'h09, 0, 8, 'h1000));
        emit(1, iType(6'h0F, 0, 9, 'hCAFE));
        emit(1, iType(6'h0D, 9, 9, 'hBABE));
        emit(1, iType(6'h2B, 8, 9, 8));         // sw $9, 8($8)
        emit(1, iType(6'h23, 8, 2, 8));         // lw $2, 8($8)
        emit(1, rType(0, 0, 0, 6'h08));
        emit(1, iType(6'h09, 0, 3, 1));
        setExpected(1, 32'hCAFE_BABE, 1'b1, 32'h0000_1008, 32'hCAFE_BABE, 7);

        // taken beq, not-taken beq, taken bne
        emit(2, iType(6'h09, 0, 8, 5));
        emit(2, iType(6'h09, 0, 9, 5));
        emit(2, iType(6'h04, 8, 9, 2));         // beq -> word 5
        emit(2, iType(6'h09, 2, 2, 1));         // delay slot
        emit(2, iType(6'h09, 2, 2, 'h10));      // skipped
        emit(2, iType(6'h04, 8, 0, 3));         // not taken
        emit(2, iType(6'h09, 2, 2, 2));
        emit(2, iType(6'h05, 8, 0, 2));         // bne -> word 10
        emit(2, iType(6'h09, 2, 2, 4));         // delay slot
        emit(2, iType(6'h09, 2, 2, 'h20));      // skipped
        emit(2, iType(6'h09, 2, 2, 8));
        emit(2, rType(0, 0, 0, 6'h08));
        emit(2, iType(6'h09, 2, 2, 'h40));
        setExpected(2, 32'h0000_004F, 1'b0, '0, '0, 11);
    endtask

    // two LFSR bits per cycle, wait state on about one cycle in four
    always @(posedge clk) begin
        waitBitA = lfsr[0];
        lfsr = lfsrNext(lfsr);
        waitBitB = lfsr[0];
        lfsr = lfsrNext(lfsr);
        waitrequest <= waitBitA & waitBitB;
    end

    always @(posedge clk) begin
        if (!reset && read && !waitrequest) begin
            readdata <= mem.exists(address) ? mem[address] : ~address;   // unwritten words
        end
        if (!reset && write && !waitrequest) begin
            mem[address] = writedata;
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > cycleLimit) begin
            $display("timeout: the CPU did not halt within %0d cycles", cycleLimit);
            $display("Simulation failed");
            $finish;
        end
    end

    task automatic runEntry(int t);
        @(posedge clk);
        reset <= 1'b1;
        mem.delete();
        for (int i = 0; i < progLen[t]; i++) begin
            mem[RESET_VECTOR + 32'(4 * i)] = progWords[t][i];
        end
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        while (active) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);  // let the checker watch the halted bus
        expV0        <= tabV0[t];
        expStore     <= tabStore[t];
        expStoreAddr <= tabStoreAddr[t];
        expStoreData <= tabStoreData[t];
        expFetches   <= tabFetches[t];
        checkNow     <= 1'b1;
        @(posedge clk);
        checkNow <= 1'b0;
    endtask

    initial begin
        reset = 1'b1;
        buildTable();
        for (int t = 0; t < NUM_TESTS; t++) begin
            cycleLimit += 20 * progLen[t] + 50;
        end
        for (int t = 0; t < NUM_TESTS; t++) begin
            runEntry(t);
        end
        @(posedge clk);
        $display("checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== bench/mipsChecker.sv ====
`timescale 1ns/1ps

module mipsChecker import mipsPkg::*; #(
    parameter wordT progBase = 32'hBFC00000
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       active,
    input  wordT       registerV0,
    input  wordT       address,
    input  logic       write,
    input  logic       read,
    input  logic       waitrequest,
    input  wordT       writedata,
    input  logic [3:0] byteenable,
    input  logic       checkNow,
    input  wordT       expV0,
    input  logic       expStore,
    input  wordT       expStoreAddr,
    input  wordT       expStoreData,
    input  int         expFetches,
    output int         errorCount,
    output int         checkCount
);

    int   fetchCount;
    int   writeCount;
    wordT storeAddr;
    wordT storeData;
    wordT haltV0;       // v0 as seen when active fell
    logic firstPending;
    logic halted;

    initial begin
        errorCount = 0;
        checkCount = 0;
    end

    task automatic compareWord(string name, wordT got, wordT want);
        checkCount++;
        if (got !== want) begin
            errorCount++;
            $display("FAIL t=%0t %s got %h expected %h", $time, name, got, want);
        end
    endtask

    task automatic complain(string what);
        errorCount++;
        $display("ERROR t=%0t %s", $time, what);
    endtask

    always @(posedge clk) begin
        if (reset) begin
            fetchCount   = 0;
            writeCount   = 0;
            firstPending = 1'b1;
            halted       = 1'b0;
            if (read || write) begin
                complain("bus request while reset is held");
            end
        end else begin
            if (firstPending) begin     // first cycle out of reset
                firstPending = 1'b0;
                compareWord("read", {31'h0, read}, 32'h1);
                compareWord("address", address, progBase);
                compareWord("write", {31'h0, write}, 32'h0);
                compareWord("active", {31'h0, active}, 32'h1);
            end
            if (read && write) begin
                complain("read and write requested in the same cycle");
            end
            if (read && address == HALT_ADDR) begin
                complain("read issued at the halt address");
            end
            if (read || write) begin
                compareWord("byteenable", {28'h0, byteenable}, 32'hF);
            end
            if (read && !waitrequest && address >= progBase && address < progBase + 32'h400) begin
                fetchCount++;
            end
            if (write && !waitrequest) begin
                writeCount++;
                storeAddr = address;
                storeData = writedata;
            end
            if (!active) begin
                if (read || write) begin
                    complain("bus request after the CPU halted");
                end
                if (!halted) begin
                    halted = 1'b1;
                    haltV0 = registerV0;
                end else begin
                    compareWord("register_v0", registerV0, haltV0);
                end
            end
            if (checkNow) begin
                compareWord("register_v0", registerV0, expV0);
                compareWord("fetch count", fetchCount, expFetches);
                compareWord("write count", writeCount, {31'h0, expStore});
                if (expStore) begin
                    compareWord("store address", storeAddr, expStoreAddr);
                    compareWord("store data", storeData, expStoreData);
                end
            end
        end
    end

endmodule

// ==== source/mipsCpuBus.sv ====
`timescale 1ns/1ps

module mipsCpuBus import mipsPkg::*; #(
    parameter wordT resetVector = 32'hBFC00000
) (
    input  logic       clk,
    input  logic       reset,
    output logic       active,
    output wordT       register_v0,
    output wordT       address,
    output logic       write,
    output logic       read,
    input  logic       waitrequest,
    output wordT       writedata,
    output logic [3:0] byteenable,
    input  wordT       readdata
);

    regAddrT regAddrA;
    regAddrT regAddrB;
    wordT    regReadA;
    wordT    regReadB;
    logic    regWriteEnable;
    regAddrT regWriteAddress;
    wordT    regWriteData;
    aluOpT   aluOp;
    wordT    aluA;
    wordT    aluB;
    wordT    aluResult;
    logic    aluZero;

    mipsControl #(
        .resetVector(resetVector)
    ) uControl (
        .clk(clk),
        .reset(reset),
        .waitrequest(waitrequest),
        .readdata(readdata),
        .active(active),
        .read(read),
        .write(write),
        .address(address),
        .writedata(writedata),
        .byteenable(byteenable),
        .regAddrA(regAddrA),
        .regAddrB(regAddrB),
        .regReadA(regReadA),
        .regReadB(regReadB),
        .regWriteEnable(regWriteEnable),
        .regWriteAddress(regWriteAddress),
        .regWriteData(regWriteData),
        .aluOp(aluOp),
        .aluA(aluA),
        .aluB(aluB),
        .aluResult(aluResult),
        .aluZero(aluZero)
    );

    mipsAlu uAlu (
        .aluOp(aluOp),
        .a(aluA),
        .b(aluB),
        .result(aluResult),
        .zero(aluZero)
    );

    mipsRegFile uRegFile (
        .clk(clk),
        .reset(reset),
        .writeEnable(regWriteEnable),
        .writeAddress(regWriteAddress),
        .writeData(regWriteData),
        .readAddressA(regAddrA),
        .readDataA(regReadA),
        .readAddressB(regAddrB),
        .readDataB(regReadB),
        .registerV0(register_v0)
    );

endmodule

// ==== control/mipsControl.sv ====
`timescale 1ns/1ps

module mipsControl import mipsPkg::*; #(
    parameter wordT resetVector = 32'hBFC00000
) (
    input  logic    clk,
    input  logic    reset,
    input  logic    waitrequest,
    input  wordT    readdata,
    output logic    active,
    output logic    read,
    output logic    write,
    output wordT    address,
    output wordT    writedata,
    output logic [3:0] byteenable,
    output regAddrT regAddrA,
    output regAddrT regAddrB,
    input  wordT    regReadA,
    input  wordT    regReadB,
    output logic    regWriteEnable,
    output regAddrT regWriteAddress,
    output wordT    regWriteData,
    output aluOpT   aluOp,
    output wordT    aluA,
    output wordT    aluB,
    input  wordT    aluResult,
    input  logic    aluZero
);

    // taken -> the next instruction is the delay slot -> then jump
    typedef enum logic [1:0] {BR_NONE, BR_TAKEN, BR_DELAY} branchT;

    cpuStateT state;
    branchT   branch;
    wordT     instr;    // instruction register
    wordT     pc;
    wordT     target;

    opCodeT  opCode;
    fnCodeT  fnCode;
    wordT    immSign;
    wordT    immZero;
    wordT    branchTarget;
    logic    isJr;
    logic    isLoad;
    logic    isStore;
    logic    fetchHalt;
    logic    stall;
    logic    takeBranch;
    logic    writesReg;

    assign opCode  = opCodeT'(instr[31:26]);
    assign fnCode  = fnCodeT'(instr[5:0]);
    assign immSign = {{16{instr[15]}}, instr[15:0]};
    assign immZero = {16'h0000, instr[15:0]};
    assign branchTarget = pc + 32'd4 + {immSign[29:0], 2'b00};

    assign isJr      = (opCode == OP_RTYPE) && (fnCode == FN_JR);
    assign isLoad    = (opCode == OP_LW);
    assign isStore   = (opCode == OP_SW);
    assign fetchHalt = (pc == HALT_ADDR);

    // no requests while reset is held
    assign read  = !reset && ((state == S_FETCH && !fetchHalt) || (state == S_MEMORY && isLoad));
    assign write = !reset && (state == S_MEMORY) && isStore;
    assign address    = (state == S_FETCH) ? pc : aluResult;
    assign writedata  = regReadB;
    assign byteenable = 4'b1111;    // word accesses only
    assign stall = (read || write) && waitrequest;

    assign regAddrA = instr[25:21];     // rs
    assign regAddrB = instr[20:16];     // rt

    always_comb begin
        aluOp     = ALU_ADD;
        writesReg = 1'b1;
        case (opCode)
            OP_RTYPE: begin
                case (fnCode)
                    FN_SUBU: aluOp = ALU_SUB;
                    FN_AND:  aluOp = ALU_AND;
                    FN_OR:   aluOp = ALU_OR;
                    FN_XOR:  aluOp = ALU_XOR;
                    FN_SLT:  aluOp = ALU_SLT;
                    FN_SLTU: aluOp = ALU_SLTU;
                    FN_ADDU: aluOp = ALU_ADD;
                    default: writesReg = 1'b0;  // JR and unknown codes
                endcase
            end
            OP_ANDI: aluOp = ALU_AND;
            OP_ORI:  aluOp = ALU_OR;
            OP_XORI: aluOp = ALU_XOR;
            OP_LUI:  aluOp = ALU_LUI;
            OP_ADDIU, OP_LW: aluOp = ALU_ADD;
            OP_BEQ, OP_BNE: begin
                aluOp     = ALU_SUB;
                writesReg = 1'b0;
            end
            default: writesReg = 1'b0;      // SW and anything unknown
        endcase
    end

    assign takeBranch = (opCode == OP_BEQ && aluZero) || (opCode == OP_BNE && !aluZero) || isJr;

    assign regWriteAddress = (opCode == OP_RTYPE) ? instr[15:11] : instr[20:16];
    assign regWriteData    = isLoad ? readdata : aluResult;
    assign regWriteEnable  = (state == S_WRITEBACK) && writesReg && (regWriteAddress != REG_ZERO);

    always_ff @(posedge clk) begin
        if (reset) begin
            state  <= S_FETCH;
            active <= 1'b1;
            pc     <= resetVector;
            branch <= BR_NONE;
        end else begin
            case (state)
                S_FETCH: begin
                    if (fetchHalt) begin
                        active <= 1'b0;
                        state  <= S_HALTED;
                    end else if (!stall) begin
                        state <= S_DECODE;
                    end
                end
                S_DECODE:  state <= S_EXECUTE;
                S_EXECUTE: state <= S_MEMORY;
                S_MEMORY: begin
                    if (!stall) begin
                        state <= S_WRITEBACK;
                        if (takeBranch) begin
                            branch <= BR_TAKEN;
                        end
                    end
                end
                S_WRITEBACK: begin
                    state  <= S_FETCH;
                    pc     <= (branch == BR_DELAY) ? target : pc + 32'd4;
                    branch <= (branch == BR_TAKEN) ? BR_DELAY : BR_NONE;
                end
                default: state <= S_HALTED;     // halted for good
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_DECODE) begin
            instr <= readdata;  // data of the fetch that just completed
        end
        if (state == S_EXECUTE) begin
            aluA <= regReadA;
            case (opCode)
                OP_RTYPE, OP_BEQ, OP_BNE:        aluB <= regReadB;
                OP_ANDI, OP_ORI, OP_XORI, OP_LUI: aluB <= immZero;
                default:                          aluB <= immSign;
            endcase
        end
        if (state == S_MEMORY && takeBranch) begin
            target <= isJr ? aluA : branchTarget;   // aluA still holds rs
        end
    end

    busExclusive: assert property (@(posedge clk) disable iff (reset) !(read && write));
    wordAligned: assert property (@(posedge clk) disable iff (reset)
        (read || write) |-> address[1:0] == 2'b00);
    requestHeld: assert property (@(posedge clk) disable iff (reset)
        stall |=> $stable({read, write, address, writedata}));

endmodule

// ==== source/mipsRegFile.sv ====
`timescale 1ns/1ps

module mipsRegFile import mipsPkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  logic    writeEnable,
    input  regAddrT writeAddress,
    input  wordT    writeData,
    input  regAddrT readAddressA,
    output wordT    readDataA,
    input  regAddrT readAddressB,
    output wordT    readDataB,
    output wordT    registerV0
);

    wordT regs [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable && writeAddress != REG_ZERO) begin
            regs[writeAddress] <= writeData;    // $zero never changes
        end
    end

    // asynchronous reads, new value shows one cycle after the write
    assign readDataA = regs[readAddressA];
    assign readDataB = regs[readAddressB];

    assign registerV0 = regs[REG_V0];

endmodule

// ==== source/mipsAlu.sv ====
`timescale 1ns/1ps

module mipsAlu import mipsPkg::*; (
    input  aluOpT aluOp,
    input  wordT  a,
    input  wordT  b,
    output wordT  result,
    output logic  zero
);

    always_comb begin
        case (aluOp)
            ALU_ADD:  result = a + b;
            ALU_SUB:  result = a - b;   // also the compare for BEQ/BNE
            ALU_AND:  result = a & b;
            ALU_OR:   result = a | b;
            ALU_XOR:  result = a ^ b;
            ALU_SLT:  result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            ALU_SLTU: result = (a < b) ? 32'd1 : 32'd0;
            ALU_LUI:  result = {b[15:0], 16'h0000};
            default:  result = '0;
        endcase
    end

    assign zero = (result == '0);

    // decode must only ever hand over one of the eight real operations
    always_comb begin
        aluOpDefined: assert final (aluOp inside {
            ALU_ADD,
            ALU_SUB,
            ALU_AND,
            ALU_OR,
            ALU_XOR,
            ALU_SLT,
            ALU_SLTU,
            ALU_LUI
        }) else begin
            $error("undefined ALU operation %0h", aluOp);
        end
    end

endmodule

// ==== common/mipsPkg.sv ====
package mipsPkg;

    typedef logic [31:0] wordT;     // data or address word
    typedef logic [4:0]  regAddrT;  // register index

    // primary opcodes still decoded by the core
    typedef enum logic [5:0] {
        OP_RTYPE = 6'b000000,
        OP_BEQ   = 6'b000100,
        OP_BNE   = 6'b000101,
        OP_ADDIU = 6'b001001,
        OP_ANDI  = 6'b001100,
        OP_ORI   = 6'b001101,
        OP_XORI  = 6'b001110,
        OP_LUI   = 6'b001111,
        OP_LW    = 6'b100011,
        OP_SW    = 6'b101011
    } opCodeT;

    // function field of R-type words
    typedef enum logic [5:0] {
        FN_JR   = 6'b001000,
        FN_ADDU = 6'b100001,
        FN_SUBU = 6'b100011,
        FN_AND  = 6'b100100,
        FN_OR   = 6'b100101,
        FN_XOR  = 6'b100110,
        FN_SLT  = 6'b101010,
        FN_SLTU = 6'b101011
    } fnCodeT;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLT  = 4'd5,
        ALU_SLTU = 4'd6,
        ALU_LUI  = 4'd7
    } aluOpT;

    // multicycle sequence, one pass per instruction
    typedef enum logic [2:0] {
        S_FETCH     = 3'b000,
        S_DECODE    = 3'b001,
        S_EXECUTE   = 3'b010,
        S_MEMORY    = 3'b011,
        S_WRITEBACK = 3'b100,
        S_HALTED    = 3'b111
    } cpuStateT;

    localparam regAddrT REG_ZERO = 5'd0;
    localparam regAddrT REG_V0   = 5'd2;   // result register seen by the outside

    // fetching from here stops the core
    localparam wordT HALT_ADDR = 32'h0000_0000;

endpackage
